// ==== run_sim.sh ====
#!/bin/bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_iadc_controller -f sim.f \
  && ./obj_dir/Vtb_iadc_controller | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }

// ==== sim.f ====
verilog/iadc_pkg.sv
verilog/iadc_wb_regs.sv
verilog/iadc_twi_serializer.sv
verilog/iadc_capture.sv
verilog/iadc_sample_fifo.sv
verilog/iadc_controller.sv
testbench/iadc_controller_asserts.sv
testbench/tb_iadc_controller.sv

// ==== testbench/iadc_controller_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module iadc_controller_asserts (
  input wire       wb_clk_i,
  input wire       wb_rst_i,
  input wire       ack_i,
  input wire       twi_busy_i,
  input wire       strobe_n_i,
  input wire [3:0] fifo_status_i,   // full, afull, aempty, empty
  input wire       ddrb_i,
  input wire       dcm_reset_i
);

  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i) else $error("wishbone ack high on two cycles in a row");

  strobe_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !twi_busy_i |-> strobe_n_i) else $error("serial strobe low while serializer idle");

  fifo_flags: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(fifo_status_i[3] && fifo_status_i[0])) else $error("fifo full and empty together");

  dcm_follow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ddrb_i |=> dcm_reset_i) else $error("dcm reset not high after ddrb pulse");

endmodule

bind iadc_controller iadc_controller_asserts asserts (
  .wb_clk_i, .wb_rst_i,
  .ack_i         (wb_ack_o),
  .twi_busy_i    (twi_busy),
  .strobe_n_i    (adc_ctrl_strobe_n_o),
  .fifo_status_i (fifo_status),
  .ddrb_i        (adc_ddrb_o),
  .dcm_reset_i   (adc_dcm_reset_o)
);

`default_nettype wire

// ==== testbench/iadc_golden.txt ====
# op and hex fields: W idx data sel | R idx expected | S sample sync oor | N sample
# F count | C count | T frame | D cycles | M level
R 1 0000
R 3 0000
R c 0000
R b 0003
R f 0000
W 1 0001 1
M 1
R 1 0001
W 2 0005 1
R 2 0005
W 3 1234 3
W 3 abcd 1
R 3 12cd
W 3 a5c3 3
W 4 0000 1
R 4 0001
W 4 0000 1
T 5a5c3
R 4 0000
D ff
S 0123456789abcdef a 5
R b 0003
W c 0001 1
R c 0001
S 0123456789abcdef a 5
N ffffffffffffffff
S fedcba9876543210 3 c
R b 0002
R 5 00a5
R 6 0123
R 7 4567
R 8 89ab
R 9 cdef
W a 0001 1
R 5 003c
R 9 3210
W a 0001 1
R b 0003
F 0e
R b 0004
C 0e
F 14
R b 000c
C 10
F 03
R b 0000
W c 0000 1
W c 0001 1
R b 0003
W 1 0000 1
M 0

// ==== testbench/tb_iadc_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_iadc_controller;

  import iadc_pkg::*;

  localparam string GOLDEN_FILE     = "testbench/iadc_golden.txt";
  localparam int    CYCLES_PER_LINE = 4000;

  logic       wb_clk_i;
  logic       wb_rst_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  logic [1:0] wb_sel_i;
  logic [31:0] wb_adr_i;
  wb_data_t   wb_dat_i;
  wb_data_t   wb_dat_o;
  logic       wb_ack_o;
  adc_word_t  adc_data_i;
  logic [3:0] adc_sync_i;
  logic [3:0] adc_outofrange_i;
  logic       adc_valid_i;
  logic       adc_ctrl_clk_o;
  logic       adc_ctrl_data_o;
  logic       adc_ctrl_strobe_n_o;
  logic       adc_mode_o;
  logic       adc_ddrb_o;
  logic       adc_dcm_reset_o;

  logic [31:0] ser_bits = '0;
  int          ser_count = 0;
  int          watchdog_cycles = 0;
  logic [31:0] fill_seed = 32'h4e18;
  logic [31:0] check_seed = 32'h4e18;  // replays the filler stream

  iadc_controller uut (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  // serial monitor, one bit per rising control clock inside the strobe window
  always @(posedge adc_ctrl_clk_o) begin
    if (!adc_ctrl_strobe_n_o) begin
      ser_bits  <= {ser_bits[30:0], adc_ctrl_data_o};
      ser_count <= ser_count + 1;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic fifo_word_t filler_word(input logic [31:0] s);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next(s);
    lo = lcg_next(hi);
    return {s[31:24], hi, lo};  // sync and oor from the seed itself
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [71:0] expected,
                       input logic [71:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  task automatic drive_bus(input logic we, input reg_addr_t idx, input wb_data_t dat,
                           input logic [1:0] sel);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {27'd0, idx, 1'b0};
    wb_dat_i = dat;
    wb_sel_i = sel;
  endtask

  task automatic release_bus();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // starts and ends just after a falling edge
  task automatic bus_access(input logic we, input reg_addr_t idx, input wb_data_t dat,
                            input logic [1:0] sel, output wb_data_t rdat);
    drive_bus(we, idx, dat, sel);
    @(negedge wb_clk_i);
    check("ack on time", 1, wb_ack_o);
    rdat = wb_dat_o;
    release_bus();
    @(negedge wb_clk_i);
    check("ack width", 0, wb_ack_o);
  endtask

  task automatic feed_sample(input fifo_word_t w, input logic valid);
    adc_sync_i       = w[71:68];
    adc_outofrange_i = w[67:64];
    adc_data_i       = w[63:0];
    adc_valid_i      = valid;
    @(negedge wb_clk_i);
    adc_valid_i = 1'b0;
  endtask

  task automatic read_word(output fifo_word_t w);
    wb_data_t d;
    for (int i = 0; i < 5; i++) begin
      bus_access(1'b0, reg_addr_t'(REG_IADC_FIFODATA_4 + i), '0, 2'b01, d);
      if (i == 0) w[71:64] = d[7:0];
      else w[63-16*(i-1) -: 16] = d;
    end
  endtask

  task automatic check_frame(input twi_frame_t frame);
    wb_data_t busy;
    busy = 16'd1;
    while (busy[0]) begin
      bus_access(1'b0, REG_IADC_TWI_TX, '0, 2'b01, busy);
    end
    check("serial bit count", 20, ser_count);
    check("serial frame", frame, ser_bits[19:1]);
    check("serial trailing bit", 0, ser_bits[0]);
  endtask

  task automatic check_reset_window(input int expected);
    int high_cycles;
    high_cycles = 0;
    drive_bus(1'b1, REG_IADC_RESET, '0, 2'b01);
    @(negedge wb_clk_i);
    check("ack on time", 1, wb_ack_o);
    check("ddrb pulse", 1, adc_ddrb_o);
    check("dcm reset early", 0, adc_dcm_reset_o);
    release_bus();
    @(negedge wb_clk_i);
    check("ack width", 0, wb_ack_o);
    check("ddrb width", 0, adc_ddrb_o);
    while (adc_dcm_reset_o && high_cycles < 4 * expected) begin
      high_cycles++;
      @(negedge wb_clk_i);
    end
    check("dcm reset window", expected, high_cycles);
  endtask

  initial begin : watchdog
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge wb_clk_i);
    stop_run("watchdog expired before the golden file was finished");
  end

  initial begin : run
    int          fd;
    int          line_no;
    string       text;
    logic [7:0]  op;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    wb_data_t    rdat;
    fifo_word_t  word;
    wb_rst_i         = 1'b1;
    wb_cyc_i         = 1'b0;
    wb_stb_i         = 1'b0;
    wb_we_i          = 1'b0;
    wb_sel_i         = 2'b00;
    wb_adr_i         = '0;
    wb_dat_i         = '0;
    adc_data_i       = '0;
    adc_sync_i       = '0;
    adc_outofrange_i = '0;
    adc_valid_i      = 1'b0;
    line_no          = 0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) stop_run("cannot open the golden file");
    while ($fgets(text, fd) > 0) watchdog_cycles += CYCLES_PER_LINE;
    $fclose(fd);
    repeat (5) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    fd = $fopen(GOLDEN_FILE, "r");
    while ($fgets(text, fd) > 0) begin
      line_no++;
      op = 8'h00;
      a  = '0;
      b  = '0;
      c  = '0;
      void'($sscanf(text, "%c %h %h %h", op, a, b, c));
      if (op == "#" || op == 8'h0a || op == 8'h0d || op == 8'h00) continue;
      case (op)
        "W": bus_access(1'b1, a[3:0], b[15:0], c[1:0], rdat);
        "R": begin
          bus_access(1'b0, a[3:0], '0, 2'b11, rdat);
          check($sformatf("read of register %0h", a[3:0]), b, rdat);
        end
        "S": feed_sample({b[3:0], c[3:0], a}, 1'b1);
        "N": feed_sample({8'h00, a}, 1'b0);     // valid low so nothing is stored
        "F": repeat (a) begin
          fill_seed = lcg_next(fill_seed);
          feed_sample(filler_word(fill_seed), 1'b1);
        end
        "C": repeat (a) begin
          check_seed = lcg_next(check_seed);
          read_word(word);
          check("filler word", filler_word(check_seed), word);
          bus_access(1'b1, REG_IADC_FIFO_ADV, 16'd1, 2'b01, rdat);
        end
        "T": check_frame(a[18:0]);
        "D": check_reset_window(int'(a));
        "M": check("mode pin", a, adc_mode_o);
        default: stop_run($sformatf("unknown operation in golden line %0d", line_no));
      endcase
    end
    $fclose(fd);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/iadc_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module iadc_capture (
  input  wire                  wb_clk_i,
  input  wire                  wb_rst_i,
  input  wire                  capture_en_i,
  input  wire                  adc_valid_i,
  input  iadc_pkg::adc_word_t  adc_data_i,
  input  wire  [3:0]           adc_sync_i,
  input  wire  [3:0]           adc_outofrange_i,
  output iadc_pkg::fifo_word_t wr_data_o,
  output logic                 wr_en_o
);

  import iadc_pkg::*;

  fifo_word_t packed_word;
  logic       take;

  // sync phases sit on top, then out-of-range, then the sample
  assign packed_word = {adc_sync_i, adc_outofrange_i, adc_data_i};
  assign take        = capture_en_i & adc_valid_i;

  // payload only moves on a qualified cycle
  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      wr_data_o <= packed_word;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= take;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/iadc_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module iadc_controller (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,
  input  wire                 wb_cyc_i,
  input  wire                 wb_stb_i,
  input  wire                 wb_we_i,
  input  wire  [1:0]          wb_sel_i,
  input  wire  [31:0]         wb_adr_i,
  input  iadc_pkg::wb_data_t  wb_dat_i,
  output iadc_pkg::wb_data_t  wb_dat_o,
  output logic                wb_ack_o,
  input  iadc_pkg::adc_word_t adc_data_i,
  input  wire  [3:0]          adc_sync_i,       // four phase samples of sync
  input  wire  [3:0]          adc_outofrange_i,
  input  wire                 adc_valid_i,
  output logic                adc_ctrl_clk_o,
  output logic                adc_ctrl_data_o,
  output logic                adc_ctrl_strobe_n_o,
  output logic                adc_mode_o,
  output logic                adc_ddrb_o,
  output logic                adc_dcm_reset_o
);

  import iadc_pkg::*;

  twi_addr_t    twi_addr;
  wb_data_t     twi_data;
  logic         twi_tx_strb;
  logic         twi_busy;
  logic         capture_en;
  logic         fifo_flush;
  logic         fifo_rd_strb;
  logic         fifo_wr_en;
  fifo_word_t   fifo_wr_data;
  fifo_word_t   fifo_rd_data;
  fifo_status_t fifo_status;

  iadc_wb_regs regs (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .twi_busy_i      (twi_busy),
    .fifo_rd_data_i  (fifo_rd_data),
    .fifo_status_i   (fifo_status),
    .twi_addr_o      (twi_addr),
    .twi_data_o      (twi_data),
    .twi_tx_strb_o   (twi_tx_strb),
    .fifo_rd_strb_o  (fifo_rd_strb),
    .fifo_flush_o    (fifo_flush),
    .capture_en_o    (capture_en),
    .adc_mode_o, .adc_ddrb_o, .adc_dcm_reset_o
  );

  // side branch to the adc configuration port
  iadc_twi_serializer twi (
    .wb_clk_i, .wb_rst_i,
    .tx_strb_i (twi_tx_strb),
    .twi_addr_i (twi_addr),
    .twi_data_i (twi_data),
    .busy_o     (twi_busy),
    .adc_ctrl_clk_o, .adc_ctrl_data_o, .adc_ctrl_strobe_n_o
  );

  iadc_capture capture (
    .wb_clk_i, .wb_rst_i,
    .capture_en_i (capture_en),
    .adc_valid_i, .adc_data_i, .adc_sync_i, .adc_outofrange_i,
    .wr_data_o    (fifo_wr_data),
    .wr_en_o      (fifo_wr_en)
  );

  iadc_sample_fifo fifo (
    .wb_clk_i, .wb_rst_i,
    .flush_i   (fifo_flush),
    .wr_en_i   (fifo_wr_en),
    .wr_data_i (fifo_wr_data),
    .rd_en_i   (fifo_rd_strb),
    .rd_data_o (fifo_rd_data),
    .status_o  (fifo_status)
  );

endmodule

`default_nettype wire

// ==== verilog/iadc_pkg.sv ====
`default_nettype none

package iadc_pkg;

  // sample fifo sizing and flag thresholds
  localparam int FIFO_DEPTH        = 16;
  localparam int FIFO_AW           = 4;
  localparam int FIFO_ALMOST_EMPTY = 2;  // at or below
  localparam int FIFO_ALMOST_FULL  = 14; // at or above

  localparam int TWI_DIV_BITS    = 7;   // 128 clocks per serial bit
  localparam int TWI_FRAME_BITS  = 19;
  localparam int DCM_WAIT_CYCLES = 255;

  typedef logic [15:0]               wb_data_t;
  typedef logic [3:0]                reg_addr_t;    // wb_adr_i[4:1]
  typedef logic [63:0]               adc_word_t;    // ch1 p3..p0, ch0 p3..p0
  typedef logic [71:0]               fifo_word_t;   // sync, oor, sample
  typedef logic [2:0]                twi_addr_t;
  typedef logic [TWI_FRAME_BITS-1:0] twi_frame_t;   // addr then data
  typedef logic [3:0]                fifo_status_t; // full, afull, aempty, empty

  localparam reg_addr_t REG_IADC_RESET       = 4'd0;
  localparam reg_addr_t REG_IADC_MODE        = 4'd1;
  localparam reg_addr_t REG_IADC_TWI_ADDR    = 4'd2;
  localparam reg_addr_t REG_IADC_TWI_DATA    = 4'd3;
  localparam reg_addr_t REG_IADC_TWI_TX      = 4'd4;
  localparam reg_addr_t REG_IADC_FIFODATA_4  = 4'd5;
  localparam reg_addr_t REG_IADC_FIFODATA_3  = 4'd6;
  localparam reg_addr_t REG_IADC_FIFODATA_2  = 4'd7;
  localparam reg_addr_t REG_IADC_FIFODATA_1  = 4'd8;
  localparam reg_addr_t REG_IADC_FIFODATA_0  = 4'd9;
  localparam reg_addr_t REG_IADC_FIFO_ADV    = 4'd10;
  localparam reg_addr_t REG_IADC_FIFO_STATUS = 4'd11;
  localparam reg_addr_t REG_IADC_FIFO_CTRL   = 4'd12;

  // serializer states, each step taken on a bit tick
  typedef enum logic [2:0] {
    TWI_IDLE,
    TWI_WAIT,   // line up with the divider
    TWI_STRB0,
    TWI_DATA,
    TWI_COMMIT,
    TWI_STRB1,
    TWI_SWAIT
  } twi_state_e;

endpackage

`default_nettype wire

// ==== verilog/iadc_sample_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module iadc_sample_fifo (
  input  wire                    wb_clk_i,
  input  wire                    wb_rst_i,
  input  wire                    flush_i,
  input  wire                    wr_en_i,
  input  iadc_pkg::fifo_word_t   wr_data_i,
  input  wire                    rd_en_i,
  output iadc_pkg::fifo_word_t   rd_data_o,
  output iadc_pkg::fifo_status_t status_o
);

  import iadc_pkg::*;

  fifo_word_t         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               empty;
  logic               do_wr;
  logic               do_rd;

  assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_wr = wr_en_i & ~full;   // drop words when full
  assign do_rd = rd_en_i & ~empty;

  always_ff @(posedge wb_clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // both or neither leave the count alone
      endcase
    end
  end

  // first word falls through
  assign rd_data_o = mem[rd_ptr];

  assign status_o = {
    full,
    (count >= (FIFO_AW+1)'(FIFO_ALMOST_FULL)),
    (count <= (FIFO_AW+1)'(FIFO_ALMOST_EMPTY)),
    empty
  };

endmodule

`default_nettype wire

// ==== verilog/iadc_twi_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module iadc_twi_serializer (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,
  input  wire                 tx_strb_i,
  input  iadc_pkg::twi_addr_t twi_addr_i,
  input  iadc_pkg::wb_data_t  twi_data_i,
  output logic                busy_o,
  output logic                adc_ctrl_clk_o,
  output logic                adc_ctrl_data_o,
  output logic                adc_ctrl_strobe_n_o
);

  import iadc_pkg::*;

  logic [TWI_DIV_BITS-1:0] div_cnt;
  logic                    tick;
  twi_state_e              state;
  twi_frame_t              frame;
  logic [4:0]              bit_cnt;   // data bits sent so far

  // free running bit-clock divider
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign tick = &div_cnt; // lands on the falling edge of the serial clock

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state   <= TWI_IDLE;
      frame   <= '0;
      bit_cnt <= '0;
    end else begin
      if (tx_strb_i && state == TWI_IDLE) begin
        frame   <= {twi_addr_i, twi_data_i};
        bit_cnt <= '0;
        state   <= TWI_WAIT;
      end
      if (tick) begin
        case (state)
          TWI_WAIT:   state <= TWI_STRB0;
          TWI_STRB0:  state <= TWI_DATA;
          TWI_DATA: begin
            frame   <= {frame[TWI_FRAME_BITS-2:0], 1'b0};
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(TWI_FRAME_BITS - 1)) begin
              state <= TWI_COMMIT;
            end
          end
          TWI_COMMIT: state <= TWI_STRB1;
          TWI_STRB1:  state <= TWI_SWAIT;
          TWI_SWAIT:  state <= TWI_IDLE;
          default:    ; // idle waits for a tx strobe
        endcase
      end
    end
  end

  assign busy_o = (state != TWI_IDLE);

  always_comb begin
    if (state == TWI_IDLE || state == TWI_WAIT) begin
      adc_ctrl_clk_o = 1'b0;
    end else begin
      adc_ctrl_clk_o = div_cnt[TWI_DIV_BITS-1];
    end
  end

  // strobe is low across the data bits and the trailing commit bit
  assign adc_ctrl_strobe_n_o = !(state == TWI_DATA || state == TWI_COMMIT);
  assign adc_ctrl_data_o     = frame[TWI_FRAME_BITS-1];

endmodule

`default_nettype wire

// ==== verilog/iadc_wb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module iadc_wb_regs (
  input  wire                    wb_clk_i,
  input  wire                    wb_rst_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire  [1:0]             wb_sel_i,
  input  wire  [31:0]            wb_adr_i,
  input  iadc_pkg::wb_data_t     wb_dat_i,
  output iadc_pkg::wb_data_t     wb_dat_o,
  output logic                   wb_ack_o,
  input  wire                    twi_busy_i,
  input  iadc_pkg::fifo_word_t   fifo_rd_data_i,
  input  iadc_pkg::fifo_status_t fifo_status_i,
  output iadc_pkg::twi_addr_t    twi_addr_o,
  output iadc_pkg::wb_data_t     twi_data_o,
  output logic                   twi_tx_strb_o,
  output logic                   fifo_rd_strb_o,
  output logic                   fifo_flush_o,
  output logic                   capture_en_o,
  output logic                   adc_mode_o,
  output logic                   adc_ddrb_o,
  output logic                   adc_dcm_reset_o
);

  import iadc_pkg::*;

  reg_addr_t  reg_idx;
  reg_addr_t  dat_src;    // index of the access being acked
  logic       access;
  logic       capture_en_d;
  logic [7:0] dcm_wait;

  assign reg_idx = wb_adr_i[4:1];
  assign access  = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge wb_clk_i) begin
    // command strobes last a single cycle
    wb_ack_o       <= 1'b0;
    twi_tx_strb_o  <= 1'b0;
    fifo_rd_strb_o <= 1'b0;
    adc_ddrb_o     <= 1'b0;
    if (wb_rst_i) begin
      dat_src      <= '0;
      twi_addr_o   <= '0;
      twi_data_o   <= '0;
      capture_en_o <= 1'b0;
      adc_mode_o   <= 1'b0;
    end else if (access) begin
      wb_ack_o <= 1'b1;
      dat_src  <= reg_idx;
      if (wb_we_i) begin
        case (reg_idx)
          REG_IADC_RESET: begin
            if (wb_sel_i[0]) adc_ddrb_o <= 1'b1;
          end
          REG_IADC_MODE: begin
            if (wb_sel_i[0]) adc_mode_o <= wb_dat_i[0];
          end
          REG_IADC_TWI_ADDR: begin
            if (wb_sel_i[0]) twi_addr_o <= wb_dat_i[2:0];
          end
          REG_IADC_TWI_DATA: begin
            if (wb_sel_i[0]) twi_data_o[7:0] <= wb_dat_i[7:0];
            if (wb_sel_i[0] && wb_sel_i[1]) twi_data_o[15:8] <= wb_dat_i[15:8];
          end
          REG_IADC_TWI_TX: begin
            if (wb_sel_i[0]) twi_tx_strb_o <= 1'b1;
          end
          REG_IADC_FIFO_ADV: begin
            if (wb_sel_i[0]) fifo_rd_strb_o <= wb_dat_i[0]; // bit 0 pops a word
          end
          REG_IADC_FIFO_CTRL: begin
            if (wb_sel_i[0]) capture_en_o <= wb_dat_i[0];
          end
          default: ; // read-only or unmapped
        endcase
      end
    end
  end

  // flush the fifo one cycle after capture is switched on
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      capture_en_d <= 1'b0;
      fifo_flush_o <= 1'b0;
    end else begin
      capture_en_d <= capture_en_o;
      fifo_flush_o <= capture_en_o & ~capture_en_d;
    end
  end

  // clock manager reset window follows the ddrb pulse
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      dcm_wait <= '0;
    end else if (adc_ddrb_o) begin
      dcm_wait <= 8'(DCM_WAIT_CYCLES);
    end else if (dcm_wait != 8'd0) begin
      dcm_wait <= dcm_wait - 8'd1;
    end
  end

  assign adc_dcm_reset_o = (dcm_wait != 8'd0);

  // read mux on the latched index
  always_comb begin
    case (dat_src)
      REG_IADC_MODE:        wb_dat_o = {15'b0, adc_mode_o};
      REG_IADC_TWI_ADDR:    wb_dat_o = {13'b0, twi_addr_o};
      REG_IADC_TWI_DATA:    wb_dat_o = twi_data_o;
      REG_IADC_TWI_TX:      wb_dat_o = {15'b0, twi_busy_i};
      REG_IADC_FIFODATA_4:  wb_dat_o = {8'b0, fifo_rd_data_i[71:64]};  // sync and oor
      REG_IADC_FIFODATA_3:  wb_dat_o = fifo_rd_data_i[63:48];
      REG_IADC_FIFODATA_2:  wb_dat_o = fifo_rd_data_i[47:32];
      REG_IADC_FIFODATA_1:  wb_dat_o = fifo_rd_data_i[31:16];
      REG_IADC_FIFODATA_0:  wb_dat_o = fifo_rd_data_i[15:0];
      REG_IADC_FIFO_STATUS: wb_dat_o = {12'b0, fifo_status_i};
      REG_IADC_FIFO_CTRL:   wb_dat_o = {15'b0, capture_en_o};
      default:              wb_dat_o = '0; // reset, advance and unmapped
    endcase
  end

endmodule

`default_nettype wire
